//--- logic/rv_csr_pkg.sv
package rv_csr_pkg;

    // Machine and user CSR addresses.
    localparam logic [11:0] CSR_MISA      = 12'h301;
    localparam logic [11:0] CSR_MSCRATCH  = 12'h340;
    localparam logic [11:0] CSR_MCYCLE    = 12'hB00;
    localparam logic [11:0] CSR_MINSTRET  = 12'hB02;
    localparam logic [11:0] CSR_MCYCLEH   = 12'hB80;
    localparam logic [11:0] CSR_MINSTRETH = 12'hB82;
    localparam logic [11:0] CSR_CYCLE     = 12'hC00;
    localparam logic [11:0] CSR_TIME      = 12'hC01;
    localparam logic [11:0] CSR_INSTRET   = 12'hC02;
    localparam logic [11:0] CSR_CYCLEH    = 12'hC80;
    localparam logic [11:0] CSR_TIMEH     = 12'hC81;
    localparam logic [11:0] CSR_INSTRETH  = 12'hC82;
    localparam logic [11:0] CSR_MVENDORID = 12'hF11;
    localparam logic [11:0] CSR_MARCHID   = 12'hF12;
    localparam logic [11:0] CSR_MIMPID    = 12'hF13;
    localparam logic [11:0] CSR_MHARTID   = 12'hF14;

    localparam logic [11:0] CSR_HPMEVENT_LO = 12'h323; // mhpmevent3..31.
    localparam logic [11:0] CSR_HPMEVENT_HI = 12'h33F;
    localparam logic [11:0] CSR_HPMCNT_LO   = 12'hB03; // mhpmcounter3..31.
    localparam logic [11:0] CSR_HPMCNT_HI   = 12'hB1F;
    localparam logic [11:0] CSR_HPMCNTH_LO  = 12'hB83; // Upper halves.
    localparam logic [11:0] CSR_HPMCNTH_HI  = 12'hB9F;

    // XLEN code 1 in bits 31:30, extension I at bit 8.
    localparam logic [31:0] MISA_VALUE = 32'h4000_0100;

    localparam logic [6:0] OPC_SYSTEM = 7'b1110011;
    localparam logic [6:0] OPC_OP_IMM = 7'b0010011;

    localparam logic [2:0] F3_ADDI   = 3'b000;
    localparam logic [2:0] F3_CSRRW  = 3'b001;
    localparam logic [2:0] F3_CSRRS  = 3'b010;
    localparam logic [2:0] F3_CSRRC  = 3'b011;
    localparam logic [2:0] F3_CSRRWI = 3'b101; // Bit 2 picks the uimm source.
    localparam logic [2:0] F3_CSRRSI = 3'b110;
    localparam logic [2:0] F3_CSRRCI = 3'b111;

    localparam logic [1:0] WOP_RW = 2'b01; // Same as funct3[1:0].
    localparam logic [1:0] WOP_RS = 2'b10;
    localparam logic [1:0] WOP_RC = 2'b11;

    localparam logic [1:0] KIND_CSR     = 2'd0;
    localparam logic [1:0] KIND_ADDI    = 2'd1;
    localparam logic [1:0] KIND_ILLEGAL = 2'd2;

    localparam logic [7:0] REG_ISSUE    = 8'h00;
    localparam logic [7:0] REG_STATUS   = 8'h04;
    localparam logic [7:0] REG_GPR_BASE = 8'h20;

    typedef union packed {
        struct packed {
            logic [11:0] imm;
            logic [4:0]  rs1;
            logic [2:0]  funct3;
            logic [4:0]  rd;
            logic [6:0]  opcode;
        } i_view;
        struct packed {
            logic [11:0] csr;
            logic [4:0]  uimm_or_rs1;
            logic [2:0]  funct3;
            logic [4:0]  rd;
            logic [6:0]  opcode;
        } csr_view;
    } instr_word_t;

endpackage

//--- logic/csr_apb_port.sv
`timescale 1ns/1ps

module csr_apb_port #(
    parameter int NUM_GPR = 8,
    localparam int IDX_W = $clog2(NUM_GPR)
) (
    input  logic             clk,
    input  logic             arst_n,
    input  logic [7:0]       paddr,
    input  logic             psel,
    input  logic             penable,
    input  logic             pwrite,
    input  logic [31:0]      pwdata,
    output logic [31:0]      prdata,
    output logic             pready,
    output logic             pslverr,
    output logic             issue_valid,
    output logic [31:0]      issue_word,
    input  logic             issue_ready,
    input  logic             busy,
    input  logic [7:0]       illegal_count,
    output logic             gpr_apb_we,
    output logic [IDX_W-1:0] gpr_apb_index,
    output logic [31:0]      gpr_apb_wdata,
    input  logic [31:0]      gpr_apb_rdata
);
    import rv_csr_pkg::*;

    logic       access;
    logic       pipe_busy;
    logic       is_issue;
    logic       is_status;
    logic       is_gpr;
    logic [7:0] gpr_off;
    logic       issue_load;

    assign access    = psel && penable;
    assign pipe_busy = issue_valid || busy;
    assign gpr_off   = paddr - REG_GPR_BASE;

    assign is_issue  = (paddr == REG_ISSUE);
    assign is_status = (paddr == REG_STATUS);
    assign is_gpr    = (paddr >= REG_GPR_BASE) && (gpr_off[7:2] < NUM_GPR);

    assign gpr_apb_index = gpr_off[IDX_W+1:2];
    assign gpr_apb_wdata = pwdata;
    assign gpr_apb_we    = access && pwrite && is_gpr && !pipe_busy;

    assign pslverr    = access && !(is_issue || is_status || is_gpr);
    assign issue_load = access && pwrite && is_issue && !issue_valid;

    always_comb begin
        pready = 1'b1;
        if (is_issue && pwrite && issue_valid) begin
            pready = 1'b0; // Slot still full.
        end
        if (is_gpr && pipe_busy) begin
            pready = 1'b0;
        end
    end

    always_comb begin
        prdata = 32'b0;
        if (is_issue) begin
            prdata = issue_word;
        end else if (is_status) begin
            prdata = {16'b0, illegal_count, 7'b0, pipe_busy};
        end else if (is_gpr) begin
            prdata = gpr_apb_rdata;
        end
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            issue_valid <= 1'b0;
        end else if (issue_load) begin
            issue_valid <= 1'b1;
        end else if (issue_valid && issue_ready) begin
            issue_valid <= 1'b0; // Taken by decode.
        end
    end

    always_ff @(posedge clk) begin
        if (issue_load) begin
            issue_word <= pwdata;
        end
    end

endmodule

//--- logic/csr_decode.sv
`timescale 1ns/1ps

module csr_decode #(
    parameter int NUM_GPR = 8,
    localparam int IDX_W = $clog2(NUM_GPR)
) (
    input  logic             clk,
    input  logic             arst_n,
    input  logic             issue_valid,
    input  logic [31:0]      issue_word,
    output logic             issue_ready,
    output logic [IDX_W-1:0] rs1_index,
    input  logic [31:0]      rs1_value,
    input  logic             wb_valid,
    input  logic [IDX_W-1:0] wb_rd,
    output logic             ex_valid,
    output logic [1:0]       ex_kind,
    output logic [11:0]      ex_csr,
    output logic [1:0]       ex_wop,
    output logic [31:0]      ex_operand,
    output logic [31:0]      ex_imm,
    output logic [IDX_W-1:0] ex_rd,
    output logic             decode_busy
);
    import rv_csr_pkg::*;

    instr_word_t word;
    logic        rd_ok;
    logic        rs1_ok;
    logic        is_csr;
    logic        is_addi;
    logic        uses_rs1;
    logic        hazard;
    logic        fire;
    logic [1:0]  kind;

    assign word    = issue_word;
    assign rd_ok   = word.i_view.rd < NUM_GPR;
    assign rs1_ok  = word.i_view.rs1 < NUM_GPR;
    assign is_csr  = (word.csr_view.opcode == OPC_SYSTEM) && (word.csr_view.funct3 inside
                     {F3_CSRRW, F3_CSRRS, F3_CSRRC, F3_CSRRWI, F3_CSRRSI, F3_CSRRCI});
    assign is_addi = (word.i_view.opcode == OPC_OP_IMM) && (word.i_view.funct3 == F3_ADDI);
    assign uses_rs1 = is_addi || (is_csr && !word.csr_view.funct3[2]);

    always_comb begin
        if (is_csr && rd_ok && (word.csr_view.funct3[2] || rs1_ok)) begin
            kind = KIND_CSR;
        end else if (is_addi && rd_ok && rs1_ok) begin
            kind = KIND_ADDI;
        end else begin
            kind = KIND_ILLEGAL;
        end
    end

    // No forwarding, so wait until the producer has written the register file.
    assign rs1_index = word.i_view.rs1[IDX_W-1:0];
    assign hazard = issue_valid && (kind != KIND_ILLEGAL) && uses_rs1 && (rs1_index != '0) &&
                    ((ex_valid && ex_rd == rs1_index) || (wb_valid && wb_rd == rs1_index));
    assign issue_ready = !hazard;
    assign fire        = issue_valid && issue_ready;
    assign decode_busy = ex_valid;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            ex_valid <= 1'b0;
        end else begin
            ex_valid <= fire;
        end
    end

    always_ff @(posedge clk) begin
        if (fire) begin
            ex_kind    <= kind;
            ex_csr     <= word.csr_view.csr;
            ex_wop     <= word.csr_view.funct3[1:0];
            ex_operand <= (is_csr && word.csr_view.funct3[2]) ?
                          {27'b0, word.csr_view.uimm_or_rs1} : rs1_value;
            ex_imm     <= {{20{word.i_view.imm[11]}}, word.i_view.imm}; // Sign extended.
            ex_rd      <= word.i_view.rd[IDX_W-1:0];
        end
    end

endmodule

//--- logic/csr_execute.sv
`timescale 1ns/1ps

module csr_execute #(
    parameter int NUM_GPR = 8,
    localparam int IDX_W = $clog2(NUM_GPR)
) (
    input  logic             clk,
    input  logic             arst_n,
    input  logic             ex_valid,
    input  logic [1:0]       ex_kind,
    input  logic [11:0]      ex_csr,
    input  logic [1:0]       ex_wop,
    input  logic [31:0]      ex_operand,
    input  logic [31:0]      ex_imm,
    input  logic [IDX_W-1:0] ex_rd,
    input  logic             retire_pulse,
    output logic             wb_valid,
    output logic             wb_write,
    output logic [IDX_W-1:0] wb_rd,
    output logic [31:0]      wb_value,
    output logic             wb_retire,
    output logic             ex_busy
);
    import rv_csr_pkg::*;

    logic [31:0] mscratch;
    logic [63:0] cycle_cnt;
    logic [63:0] instret_cnt;
    logic [31:0] read_value;
    logic [31:0] new_value;
    logic        csr_known;
    logic        legal;

    always_comb begin
        csr_known  = 1'b1;
        read_value = 32'b0;
        case (ex_csr) inside
            CSR_MISA:                             read_value = MISA_VALUE;
            CSR_MSCRATCH:                         read_value = mscratch;
            CSR_MCYCLE, CSR_CYCLE, CSR_TIME:      read_value = cycle_cnt[31:0];
            CSR_MCYCLEH, CSR_CYCLEH, CSR_TIMEH:   read_value = cycle_cnt[63:32];
            CSR_MINSTRET, CSR_INSTRET:            read_value = instret_cnt[31:0];
            CSR_MINSTRETH, CSR_INSTRETH:          read_value = instret_cnt[63:32];
            [CSR_HPMEVENT_LO:CSR_HPMEVENT_HI],
            [CSR_HPMCNT_LO:CSR_HPMCNT_HI],
            [CSR_HPMCNTH_LO:CSR_HPMCNTH_HI],
            CSR_MVENDORID, CSR_MARCHID,
            CSR_MIMPID, CSR_MHARTID:              read_value = 32'b0;
            default: begin
                csr_known  = 1'b0; // Reads zero, flagged illegal.
                read_value = 32'b0;
            end
        endcase
    end

    always_comb begin
        case (ex_wop)
            WOP_RW:  new_value = ex_operand;
            WOP_RS:  new_value = read_value | ex_operand;
            WOP_RC:  new_value = read_value & ~ex_operand;
            default: new_value = read_value;
        endcase
    end

    assign legal   = ((ex_kind == KIND_CSR) && csr_known) || (ex_kind == KIND_ADDI);
    assign ex_busy = wb_valid;

    // Only mscratch is writable; counter writes are dropped.
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            mscratch <= 32'b0;
        end else if (ex_valid && ex_kind == KIND_CSR && ex_csr == CSR_MSCRATCH) begin
            mscratch <= new_value;
        end
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            cycle_cnt   <= 64'b0;
            instret_cnt <= 64'b0;
        end else begin
            cycle_cnt   <= cycle_cnt + 64'd1;
            instret_cnt <= instret_cnt + {63'b0, retire_pulse};
        end
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            wb_valid  <= 1'b0;
            wb_write  <= 1'b0;
            wb_retire <= 1'b0;
        end else begin
            wb_valid  <= ex_valid;
            wb_write  <= ex_valid && legal && (ex_rd != '0);
            wb_retire <= ex_valid && legal;
        end
    end

    always_ff @(posedge clk) begin
        if (ex_valid) begin
            wb_rd    <= ex_rd;
            wb_value <= (ex_kind == KIND_ADDI) ? ex_operand + ex_imm : read_value;
        end
    end

endmodule

//--- logic/gpr_writeback.sv
`timescale 1ns/1ps

module gpr_writeback #(
    parameter int NUM_GPR = 8,
    localparam int IDX_W = $clog2(NUM_GPR)
) (
    input  logic             clk,
    input  logic             arst_n,
    input  logic             wb_valid,
    input  logic             wb_write,
    input  logic [IDX_W-1:0] wb_rd,
    input  logic [31:0]      wb_value,
    input  logic             wb_retire,
    input  logic [IDX_W-1:0] rs1_index,
    output logic [31:0]      rs1_value,
    input  logic             gpr_apb_we,
    input  logic [IDX_W-1:0] gpr_apb_index,
    input  logic [31:0]      gpr_apb_wdata,
    output logic [31:0]      gpr_apb_rdata,
    output logic             retire_pulse,
    output logic [7:0]       illegal_count,
    output logic             wb_busy
);
    logic [31:0] gpr [NUM_GPR];

    // x0 is never stored, its reads are forced to zero.
    assign rs1_value     = (rs1_index == '0) ? 32'b0 : gpr[rs1_index];
    assign gpr_apb_rdata = (gpr_apb_index == '0) ? 32'b0 : gpr[gpr_apb_index];

    always_ff @(posedge clk) begin
        if (wb_valid && wb_write) begin
            gpr[wb_rd] <= wb_value;
        end else if (gpr_apb_we && gpr_apb_index != '0) begin
            gpr[gpr_apb_index] <= gpr_apb_wdata; // Only while the pipeline is idle.
        end
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            retire_pulse  <= 1'b0;
            illegal_count <= 8'd0;
        end else begin
            retire_pulse <= wb_valid && wb_retire;
            if (wb_valid && !wb_retire && illegal_count != 8'hFF) begin
                illegal_count <= illegal_count + 8'd1; // Saturates.
            end
        end
    end

    // Pending instret update still counts as work in flight.
    assign wb_busy = retire_pulse;

endmodule

//--- logic/csr_unit_top.sv
`timescale 1ns/1ps

module csr_unit_top #(
    parameter int NUM_GPR = 8,
    localparam int IDX_W = $clog2(NUM_GPR)
) (
    input  logic        clk,
    input  logic        arst_n,
    input  logic [7:0]  paddr,
    input  logic        psel,
    input  logic        penable,
    input  logic        pwrite,
    input  logic [31:0] pwdata,
    output logic [31:0] prdata,
    output logic        pready,
    output logic        pslverr
);
    logic             issue_valid;
    logic [31:0]      issue_word;
    logic             issue_ready;
    logic             busy;
    logic [7:0]       illegal_count;
    logic             gpr_apb_we;
    logic [IDX_W-1:0] gpr_apb_index;
    logic [31:0]      gpr_apb_wdata;
    logic [31:0]      gpr_apb_rdata;
    logic [IDX_W-1:0] rs1_index;
    logic [31:0]      rs1_value;
    logic             ex_valid;
    logic [1:0]       ex_kind;
    logic [11:0]      ex_csr;
    logic [1:0]       ex_wop;
    logic [31:0]      ex_operand;
    logic [31:0]      ex_imm;
    logic [IDX_W-1:0] ex_rd;
    logic             wb_valid;
    logic             wb_write;
    logic [IDX_W-1:0] wb_rd;
    logic [31:0]      wb_value;
    logic             wb_retire;
    logic             retire_pulse;
    logic             decode_busy;
    logic             ex_busy;
    logic             wb_busy;

    assign busy = decode_busy || ex_busy || wb_busy;

    csr_apb_port #(.NUM_GPR(NUM_GPR)) u_apb_port (
        .clk(clk), .arst_n(arst_n), .paddr(paddr), .psel(psel), .penable(penable),
        .pwrite(pwrite), .pwdata(pwdata), .prdata(prdata), .pready(pready),
        .pslverr(pslverr), .issue_valid(issue_valid), .issue_word(issue_word),
        .issue_ready(issue_ready), .busy(busy), .illegal_count(illegal_count),
        .gpr_apb_we(gpr_apb_we), .gpr_apb_index(gpr_apb_index),
        .gpr_apb_wdata(gpr_apb_wdata), .gpr_apb_rdata(gpr_apb_rdata)
    );

    csr_decode #(.NUM_GPR(NUM_GPR)) u_decode (
        .clk(clk), .arst_n(arst_n), .issue_valid(issue_valid), .issue_word(issue_word),
        .issue_ready(issue_ready), .rs1_index(rs1_index), .rs1_value(rs1_value),
        .wb_valid(wb_valid), .wb_rd(wb_rd), .ex_valid(ex_valid), .ex_kind(ex_kind),
        .ex_csr(ex_csr), .ex_wop(ex_wop), .ex_operand(ex_operand), .ex_imm(ex_imm),
        .ex_rd(ex_rd), .decode_busy(decode_busy)
    );

    csr_execute #(.NUM_GPR(NUM_GPR)) u_execute (
        .clk(clk), .arst_n(arst_n), .ex_valid(ex_valid), .ex_kind(ex_kind),
        .ex_csr(ex_csr), .ex_wop(ex_wop), .ex_operand(ex_operand), .ex_imm(ex_imm),
        .ex_rd(ex_rd), .retire_pulse(retire_pulse), .wb_valid(wb_valid),
        .wb_write(wb_write), .wb_rd(wb_rd), .wb_value(wb_value),
        .wb_retire(wb_retire), .ex_busy(ex_busy)
    );

    gpr_writeback #(.NUM_GPR(NUM_GPR)) u_writeback (
        .clk(clk), .arst_n(arst_n), .wb_valid(wb_valid), .wb_write(wb_write),
        .wb_rd(wb_rd), .wb_value(wb_value), .wb_retire(wb_retire),
        .rs1_index(rs1_index), .rs1_value(rs1_value), .gpr_apb_we(gpr_apb_we),
        .gpr_apb_index(gpr_apb_index), .gpr_apb_wdata(gpr_apb_wdata),
        .gpr_apb_rdata(gpr_apb_rdata), .retire_pulse(retire_pulse),
        .illegal_count(illegal_count), .wb_busy(wb_busy)
    );

endmodule

//--- test/csr_unit_tb.sv
`timescale 1ns/1ps

module csr_unit_tb;
    import rv_csr_pkg::*;

    localparam int NUM_GPR       = 8;
    localparam int CLK_PERIOD    = 4;
    localparam int NUM_RANDOM    = 24;
    localparam int PLANNED_INSTR = NUM_RANDOM + 24;

    logic        clk = 1'b0;
    logic        arst_n;
    logic [7:0]  paddr;
    logic        psel;
    logic        penable;
    logic        pwrite;
    logic [31:0] pwdata;
    logic [31:0] prdata;
    logic        pready;
    logic        pslverr;

    logic [31:0] gpr_model [NUM_GPR];
    logic [31:0] mscratch_model;
    int          instret_model;
    int          illegal_model;
    int          seed;
    int          cycle_no = 0;
    int          n_issued;
    int          value_errors;
    int          protocol_errors;
    logic        check_rdata;
    logic [31:0] exp_rdata;
    logic        exp_err;
    logic [31:0] last_rdata;
    int          last_waits;
    int          last_accept_cycle;

    csr_unit_top #(.NUM_GPR(NUM_GPR)) DUT (
        .clk(clk), .arst_n(arst_n), .paddr(paddr), .psel(psel), .penable(penable),
        .pwrite(pwrite), .pwdata(pwdata), .prdata(prdata), .pready(pready),
        .pslverr(pslverr)
    );

    always #(CLK_PERIOD / 2) clk = ~clk;

    always @(posedge clk) begin
        cycle_no <= cycle_no + 1;
    end

    // Falling edge, where the DUT outputs have settled.
    always @(negedge clk) begin
        if (arst_n) begin
            assert (!pslverr || (psel && penable)) else begin
                protocol_errors++;
                $display("pslverr was raised outside an access phase at %0t", $time);
            end
            if (psel && penable && pready) begin
                assert (pslverr === exp_err) else begin
                    protocol_errors++;
                    $display("pslverr was %b at address 0x%02h, it should be %b",
                             pslverr, paddr, exp_err);
                end
                if (check_rdata) begin
                    assert (prdata === exp_rdata) else begin
                        value_errors++;
                        $display("ERROR %0t: read at 0x%02h returned %h, expected %h",
                                 $time, paddr, prdata, exp_rdata);
                    end
                end
            end
        end
    end

    initial begin
        #(PLANNED_INSTR * 40 * CLK_PERIOD + 2000);
        $display("Watchdog expired, the run did not finish in time");
        $display("TEST FAIL");
        $finish;
    end

    function automatic logic [31:0] csr_instr(input logic [2:0] f3, input logic [11:0] csr,
                                              input logic [4:0] src, input logic [4:0] rd);
        instr_word_t w;
        w.csr_view.csr         = csr;
        w.csr_view.uimm_or_rs1 = src;
        w.csr_view.funct3      = f3;
        w.csr_view.rd          = rd;
        w.csr_view.opcode      = OPC_SYSTEM;
        return w;
    endfunction

    function automatic logic [31:0] addi_instr(input logic [4:0] rd, input logic [4:0] rs1,
                                               input logic [11:0] imm);
        instr_word_t w;
        w.i_view.imm    = imm;
        w.i_view.rs1    = rs1;
        w.i_view.funct3 = F3_ADDI;
        w.i_view.rd     = rd;
        w.i_view.opcode = OPC_OP_IMM;
        return w;
    endfunction

    function automatic logic [2:0] csr_op(input int n);
        case (n)
            0:       return F3_CSRRW;
            1:       return F3_CSRRS;
            2:       return F3_CSRRC;
            3:       return F3_CSRRWI;
            4:       return F3_CSRRSI;
            default: return F3_CSRRCI;
        endcase
    endfunction

    function automatic bit known_csr(input logic [11:0] a);
        case (a)
            CSR_MISA, CSR_MSCRATCH, CSR_MCYCLE, CSR_MINSTRET, CSR_MCYCLEH, CSR_MINSTRETH,
            CSR_CYCLE, CSR_TIME, CSR_INSTRET, CSR_CYCLEH, CSR_TIMEH, CSR_INSTRETH,
            CSR_MVENDORID, CSR_MARCHID, CSR_MIMPID, CSR_MHARTID: return 1'b1;
            default: return (a >= CSR_HPMEVENT_LO && a <= CSR_HPMEVENT_HI) ||
                            (a >= CSR_HPMCNT_LO && a <= CSR_HPMCNT_HI) ||
                            (a >= CSR_HPMCNTH_LO && a <= CSR_HPMCNTH_HI);
        endcase
    endfunction

    // Counters other than instret are not predicted here.
    function automatic logic [31:0] model_csr(input logic [11:0] a);
        case (a)
            CSR_MISA:                  return MISA_VALUE;
            CSR_MSCRATCH:              return mscratch_model;
            CSR_MINSTRET, CSR_INSTRET: return instret_model;
            default:                   return 32'b0;
        endcase
    endfunction

    function automatic logic [31:0] csr_update(input logic [2:0] f3, input logic [31:0] old_val,
                                               input logic [31:0] op);
        if (f3 == F3_CSRRW || f3 == F3_CSRRWI) begin
            return op;
        end else if (f3 == F3_CSRRS || f3 == F3_CSRRSI) begin
            return old_val | op;
        end
        return old_val & ~op;
    endfunction

    task automatic apb_xfer(input logic [7:0] addr, input logic wr, input logic [31:0] wdata,
                            input logic chk, input logic [31:0] rexp, input logic err);
        paddr       = addr;
        pwrite      = wr;
        pwdata      = wdata;
        exp_rdata   = rexp;
        exp_err     = err;
        check_rdata = chk;
        psel        = 1'b1;
        penable     = 1'b0;
        @(posedge clk);
        #1;
        penable    = 1'b1;
        last_waits = 0;
        @(negedge clk);
        while (!pready) begin
            last_waits++;
            @(negedge clk);
        end
        last_rdata        = prdata;
        last_accept_cycle = cycle_no;
        @(posedge clk);
        #1;
        psel        = 1'b0;
        penable     = 1'b0;
        check_rdata = 1'b0;
    endtask

    task automatic issue(input logic [31:0] word);
        apb_xfer(REG_ISSUE, 1'b1, word, 1'b0, 32'b0, 1'b0);
        n_issued++;
    endtask

    task automatic check_gpr(input int idx, input logic [31:0] exp);
        apb_xfer(REG_GPR_BASE + 8'(4 * idx), 1'b0, 32'b0, 1'b1, exp, 1'b0);
    endtask

    task automatic write_gpr(input int idx, input logic [31:0] data);
        apb_xfer(REG_GPR_BASE + 8'(4 * idx), 1'b1, data, 1'b0, 32'b0, 1'b0);
        if (idx != 0) begin
            gpr_model[idx] = data;
        end
    endtask

    task automatic check_all_gprs();
        for (int i = 0; i < NUM_GPR; i++) begin
            check_gpr(i, gpr_model[i]);
        end
    endtask

    // The x0 read waits for the pipeline to drain first.
    task automatic check_status();
        check_gpr(0, 32'b0);
        apb_xfer(REG_STATUS, 1'b0, 32'b0, 1'b1, {16'b0, illegal_model[7:0], 8'b0}, 1'b0);
    endtask

    task automatic run_csr(input logic [2:0] f3, input logic [11:0] csr,
                           input logic [4:0] src, input logic [4:0] rd);
        logic        legal;
        logic [31:0] old_val;
        logic [31:0] operand;
        legal   = known_csr(csr) && rd < NUM_GPR && (f3[2] || src < NUM_GPR);
        old_val = model_csr(csr);
        operand = f3[2] ? {27'b0, src} : ((src < NUM_GPR) ? gpr_model[src] : 32'b0);
        issue(csr_instr(f3, csr, src, rd));
        if (legal) begin
            if (csr == CSR_MSCRATCH) begin
                mscratch_model = csr_update(f3, old_val, operand);
            end
            if (rd != 0) begin
                gpr_model[rd] = old_val;
            end
            instret_model++;
            check_gpr(rd, gpr_model[rd]);
        end else begin
            illegal_model++;
            check_status();
        end
    endtask

    task automatic run_illegal_word(input logic [31:0] word);
        issue(word);
        illegal_model++;
        check_status();
    endtask

    initial begin
        logic [2:0]  f3;
        logic [4:0]  src;
        logic [4:0]  rd;
        logic [11:0] imm1;
        logic [11:0] imm2;
        logic [31:0] v1;
        logic [31:0] v2;
        int          a1;
        int          a2;
        arst_n          = 1'b0;
        paddr           = 8'b0;
        psel            = 1'b0;
        penable         = 1'b0;
        pwrite          = 1'b0;
        pwdata          = 32'b0;
        check_rdata     = 1'b0;
        exp_rdata       = 32'b0;
        exp_err         = 1'b0;
        seed            = 32631;
        n_issued        = 0;
        value_errors    = 0;
        protocol_errors = 0;
        instret_model   = 0;
        illegal_model   = 0;
        mscratch_model  = 32'b0;
        gpr_model[0]    = 32'b0;
        repeat (16) @(posedge clk);
        #1;
        arst_n = 1'b1;

        apb_xfer(REG_STATUS, 1'b0, 32'b0, 1'b1, 32'b0, 1'b0);
        for (int i = 1; i < NUM_GPR; i++) begin
            write_gpr(i, $random(seed));
        end
        run_csr(F3_CSRRS, CSR_MISA, 5'd0, 5'd1);
        run_csr(F3_CSRRS, CSR_HPMEVENT_LO, 5'd0, 5'd2);
        run_csr(F3_CSRRS, CSR_HPMEVENT_HI, 5'd0, 5'd3);
        run_csr(F3_CSRRS, 12'hB05, 5'd0, 5'd4);
        run_csr(F3_CSRRS, CSR_HPMCNTH_HI, 5'd0, 5'd5);
        run_csr(F3_CSRRS, CSR_MVENDORID, 5'd0, 5'd2);
        run_csr(F3_CSRRS, CSR_MARCHID, 5'd0, 5'd3);
        run_csr(F3_CSRRS, CSR_MIMPID, 5'd0, 5'd4);
        run_csr(F3_CSRRS, CSR_MHARTID, 5'd0, 5'd5);

        // Each of the six CSR ops comes up in turn, with random operands.
        for (int i = 0; i < NUM_RANDOM; i++) begin
            f3 = csr_op(i % 6);
            rd = 5'(1 + $unsigned($random(seed)) % 7);
            if (f3[2]) begin
                src = 5'($random(seed)); // Immediate form, uimm operand.
            end else begin
                src = 5'(1 + $unsigned($random(seed)) % 7);
                write_gpr(src, $random(seed));
            end
            run_csr(f3, CSR_MSCRATCH, src, rd);
        end
        run_csr(F3_CSRRS, CSR_MSCRATCH, 5'd0, 5'd7);

        // Back to back, so the second read is accepted two edges later.
        issue(csr_instr(F3_CSRRS, CSR_MCYCLE, 5'd0, 5'd1));
        a1 = last_accept_cycle;
        issue(csr_instr(F3_CSRRS, CSR_MCYCLE, 5'd0, 5'd2));
        a2 = last_accept_cycle;
        apb_xfer(REG_GPR_BASE + 8'd4, 1'b0, 32'b0, 1'b0, 32'b0, 1'b0);
        v1 = last_rdata;
        apb_xfer(REG_GPR_BASE + 8'd8, 1'b0, 32'b0, 1'b0, 32'b0, 1'b0);
        v2 = last_rdata;
        assert (v2 - v1 === 32'(a2 - a1)) else begin
            value_errors++;
            $display("ERROR %0t: mcycle advanced by %0d, expected %0d", $time, v2 - v1, a2 - a1);
        end
        gpr_model[1] = v1;
        gpr_model[2] = v2;
        instret_model += 2;
        run_csr(F3_CSRRS, CSR_MINSTRET, 5'd0, 5'd6);

        // Dependent chain; the third word finds the issue slot still full.
        imm1 = 12'($random(seed));
        imm2 = 12'($random(seed));
        issue(addi_instr(5'd3, 5'd0, imm1));
        issue(addi_instr(5'd4, 5'd3, imm2));
        issue(csr_instr(F3_CSRRW, CSR_MSCRATCH, 5'd4, 5'd5));
        assert (last_waits > 0) else begin
            protocol_errors++;
            $display("Issue write to a full slot completed without pready held low");
        end
        gpr_model[3]   = {{20{imm1[11]}}, imm1};
        gpr_model[4]   = gpr_model[3] + {{20{imm2[11]}}, imm2};
        gpr_model[5]   = mscratch_model;
        mscratch_model = gpr_model[4];
        instret_model += 3;
        check_all_gprs();

        apb_xfer(8'h10, 1'b0, 32'b0, 1'b0, 32'b0, 1'b1);
        apb_xfer(REG_GPR_BASE + 8'd32, 1'b1, 32'h1234_5678, 1'b0, 32'b0, 1'b1);

        run_illegal_word(32'h0000_0000);
        run_illegal_word(32'hFFFF_FFFF);
        run_illegal_word(csr_instr(3'b100, CSR_MSCRATCH, 5'd1, 5'd1));
        run_csr(F3_CSRRW, 12'h7C0, 5'd3, 5'd1);
        run_csr(F3_CSRRS, CSR_MSCRATCH, 5'd0, 5'd9);
        run_illegal_word(addi_instr(5'd12, 5'd1, 12'h005));
        check_all_gprs();
        run_csr(F3_CSRRS, CSR_MINSTRET, 5'd0, 5'd6);
        run_csr(F3_CSRRS, CSR_MSCRATCH, 5'd0, 5'd7);

        $display("Finished: %0d value errors, %0d protocol errors, %0d instructions issued",
                 value_errors, protocol_errors, n_issued);
        if (value_errors == 0 && protocol_errors == 0) begin
            $display("TEST PASS");
        end else begin
            $display("TEST FAIL");
        end
        $finish;
    end

endmodule

//--- files.f
logic/rv_csr_pkg.sv
logic/csr_apb_port.sv
logic/csr_decode.sv
logic/csr_execute.sv
logic/gpr_writeback.sv
logic/csr_unit_top.sv
test/csr_unit_tb.sv
